//--- common/lc3_defs.svh
/*
 * LC-3 core global macros: word width, register count,
 * PC value after reset and the opcode field position
 */
`ifndef LC3_DEFS_SVH
`define LC3_DEFS_SVH

// data and address width
`define LC3_WORD_W 16

// general purpose registers R0..R7
`define LC3_NUM_REGS 8

// first instruction fetched after reset
`define LC3_RESET_PC 16'h3000

// opcode lives in IR[15:12]
`define LC3_OPC_HI 15
`define LC3_OPC_LO 12

`endif

//--- common/lc3_pkg.sv
/*
 * LC-3 shared types: machine word, register index, opcodes,
 * microstates (state-chart numbering), branch condition select,
 * mux encodings and the datapath control word
 */
`include "lc3_defs.svh"

package lc3_pkg;

    typedef logic [`LC3_WORD_W-1:0] word_t;
    typedef logic [$clog2(`LC3_NUM_REGS)-1:0] reg_idx_t;

    typedef enum logic [`LC3_OPC_HI-`LC3_OPC_LO:0] {
        OP_BR   = 4'd0,
        OP_ADD  = 4'd1,
        OP_LD   = 4'd2,
        OP_ST   = 4'd3,
        OP_JSR  = 4'd4,
        OP_AND  = 4'd5,
        OP_LDR  = 4'd6,
        OP_STR  = 4'd7,
        OP_RTI  = 4'd8,
        OP_NOT  = 4'd9,
        OP_LDI  = 4'd10,
        OP_STI  = 4'd11,
        OP_JMP  = 4'd12,
        OP_RSV  = 4'd13,
        OP_LEA  = 4'd14,
        OP_TRAP = 4'd15
    } opcode_t;

    // numbering follows the LC-3 state chart so that branch
    // conditions can be ORed into bits 2..0 of a target
    typedef enum logic [5:0] {
        S_BR       = 6'd0,   // states 0..15 are the opcode dispatch targets
        S_ADD      = 6'd1,
        S_LD       = 6'd2,
        S_ST       = 6'd3,
        S_JSR      = 6'd4,
        S_AND      = 6'd5,
        S_LDR      = 6'd6,
        S_STR      = 6'd7,
        S_RTI_NOP  = 6'd8,
        S_NOT      = 6'd9,
        S_LDI      = 6'd10,
        S_STI      = 6'd11,
        S_JMP      = 6'd12,
        S_RSV_NOP  = 6'd13,
        S_LEA      = 6'd14,
        S_TRAP_NOP = 6'd15,
        S_ST_WR    = 6'd16,
        S_FETCH1   = 6'd18,
        S_JSRR_PC  = 6'd20,
        S_JSR_PC   = 6'd21,
        S_BR_TAKEN = 6'd22,
        S_ST_MDR   = 6'd23,
        S_LDI_RD   = 6'd24,
        S_LD_RD    = 6'd25,
        S_LDI_MAR  = 6'd26,
        S_LD_WB    = 6'd27,
        S_STI_RD   = 6'd29,
        S_STI_MAR  = 6'd31,
        S_DECODE   = 6'd32,
        S_FETCH2   = 6'd33,
        S_FETCH3   = 6'd35
    } ustate_t;

    // which condition the microsequencer folds into the target
    typedef enum logic [1:0] {
        COND_NONE  = 2'd0,
        COND_READY = 2'd1,   // bit 1
        COND_BEN   = 2'd2,   // bit 2
        COND_IR11  = 2'd3    // bit 0
    } cond_t;

    typedef enum logic [1:0] {PC_INC, PC_BUS, PC_ADDER} pcmux_t;
    typedef enum logic [1:0] {A2_ZERO, A2_OFF6, A2_OFF9, A2_OFF11} addr2mux_t;
    typedef enum logic [1:0] {ALU_ADD, ALU_AND, ALU_NOT, ALU_PASS} aluk_t;

    typedef struct packed {
        logic      ld_ben;
        logic      ld_mar;
        logic      ld_mdr;
        logic      ld_ir;
        logic      ld_pc;
        logic      ld_reg;
        logic      ld_cc;
        logic      gate_marmux;  // address adder onto the bus
        logic      gate_mdr;
        logic      gate_alu;
        logic      gate_pc;
        pcmux_t    pcmux;
        logic      addr1mux;     // 0 PC, 1 SR1
        addr2mux_t addr2mux;
        logic      drmux;        // 0 IR[11:9], 1 R7
        logic      sr1mux;       // 0 IR[11:9], 1 IR[8:6]
        aluk_t     aluk;
        logic      mem_en;       // also selects memory as MDR source
        logic      mem_we;
    } ctrl_word_t;

endpackage

//--- control/lc3_microseq.sv
/*
 * LC-3 microsequencer: opcode dispatch on IRD, otherwise
 * the selected branch condition ORed into the target state
 */
`timescale 1ns/1ps

module lc3_microseq (
    input  lc3_pkg::ustate_t target,
    input  lc3_pkg::cond_t   cond_sel,
    input  logic             ird,
    input  logic             ready,
    input  logic             ben,
    input  logic             ir_11,
    output lc3_pkg::ustate_t next_state
);

    logic [5:0] j;

    always_comb begin
        j = target;
        case (cond_sel)
            lc3_pkg::COND_READY: j[1] = j[1] | ready;
            lc3_pkg::COND_BEN:   j[2] = j[2] | ben;
            lc3_pkg::COND_IR11:  j[0] = j[0] | ir_11;
            default:             j = target;
        endcase
        if (ird) begin
            // decode puts the opcode on the target, J = {00, IR[15:12]}
            next_state = lc3_pkg::ustate_t'({2'b00, target[3:0]});
        end else begin
            next_state = lc3_pkg::ustate_t'(j);
        end
    end

endmodule

//--- control/lc3_ctrl.sv
/*
 * LC-3 control unit: microstate register, microcode ROM
 * (control word, target state, condition select per state)
 * and the microsequencer instance
 */
`timescale 1ns/1ps
`include "lc3_defs.svh"

module lc3_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  lc3_pkg::word_t      ir,
    input  logic                ben,
    input  logic                mem_ready,
    output lc3_pkg::ctrl_word_t ctrl,
    output logic                mem_en,
    output logic                mem_we
);

    lc3_pkg::ustate_t    state;
    lc3_pkg::ustate_t    next_state;
    lc3_pkg::ustate_t    target;
    lc3_pkg::cond_t      cond_sel;
    lc3_pkg::ctrl_word_t rom_cw;
    lc3_pkg::opcode_t    opcode;
    logic                ird;

    assign opcode = lc3_pkg::opcode_t'(ir[`LC3_OPC_HI:`LC3_OPC_LO]);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= lc3_pkg::S_FETCH1;
        end else begin
            state <= next_state;
        end
    end

    // microcode ROM, everything defaults to idle and back to fetch
    always_comb begin
        rom_cw   = '0;
        target   = lc3_pkg::S_FETCH1;
        cond_sel = lc3_pkg::COND_NONE;
        ird      = 1'b0;
        case (state)
            lc3_pkg::S_FETCH1: begin    // MAR <- PC, PC <- PC+1
                rom_cw.gate_pc = 1'b1;
                rom_cw.ld_mar  = 1'b1;
                rom_cw.ld_pc   = 1'b1;
                rom_cw.pcmux   = lc3_pkg::PC_INC;
                target         = lc3_pkg::S_FETCH2;
            end
            lc3_pkg::S_FETCH2, lc3_pkg::S_LDI_RD, lc3_pkg::S_LD_RD,
            lc3_pkg::S_STI_RD: begin
                // MDR <- M[MAR], spin until ready sets bit 1
                rom_cw.mem_en = 1'b1;
                rom_cw.ld_mdr = 1'b1;
                target        = state;
                cond_sel      = lc3_pkg::COND_READY;
            end
            lc3_pkg::S_FETCH3: begin
                rom_cw.gate_mdr = 1'b1;
                rom_cw.ld_ir    = 1'b1;
                target          = lc3_pkg::S_DECODE;
            end
            lc3_pkg::S_DECODE: begin    // BEN latch, opcode dispatch
                rom_cw.ld_ben = 1'b1;
                ird           = 1'b1;
                target        = lc3_pkg::ustate_t'({2'b00, opcode});
            end
            lc3_pkg::S_ADD, lc3_pkg::S_AND, lc3_pkg::S_NOT: begin
                rom_cw.gate_alu = 1'b1;
                rom_cw.ld_reg   = 1'b1;
                rom_cw.ld_cc    = 1'b1;
                rom_cw.sr1mux   = 1'b1;
                rom_cw.aluk     = (state == lc3_pkg::S_ADD) ? lc3_pkg::ALU_ADD :
                                  (state == lc3_pkg::S_AND) ? lc3_pkg::ALU_AND :
                                                              lc3_pkg::ALU_NOT;
            end
            lc3_pkg::S_LEA: begin       // no CC update on LEA
                rom_cw.gate_marmux = 1'b1;
                rom_cw.ld_reg      = 1'b1;
                rom_cw.addr2mux    = lc3_pkg::A2_OFF9;
            end
            lc3_pkg::S_LD, lc3_pkg::S_LDI, lc3_pkg::S_ST, lc3_pkg::S_STI: begin
                rom_cw.gate_marmux = 1'b1;   // MAR <- PC + off9
                rom_cw.ld_mar      = 1'b1;
                rom_cw.addr2mux    = lc3_pkg::A2_OFF9;
                target = (state == lc3_pkg::S_LD)  ? lc3_pkg::S_LD_RD  :
                         (state == lc3_pkg::S_LDI) ? lc3_pkg::S_LDI_RD :
                         (state == lc3_pkg::S_STI) ? lc3_pkg::S_STI_RD :
                                                     lc3_pkg::S_ST_MDR;
            end
            lc3_pkg::S_LDR, lc3_pkg::S_STR: begin
                rom_cw.gate_marmux = 1'b1;   // MAR <- BaseR + off6
                rom_cw.ld_mar      = 1'b1;
                rom_cw.addr1mux    = 1'b1;
                rom_cw.sr1mux      = 1'b1;
                rom_cw.addr2mux    = lc3_pkg::A2_OFF6;
                target = (state == lc3_pkg::S_LDR) ? lc3_pkg::S_LD_RD : lc3_pkg::S_ST_MDR;
            end
            lc3_pkg::S_LDI_MAR, lc3_pkg::S_STI_MAR: begin
                rom_cw.gate_mdr = 1'b1;       // pointer into MAR
                rom_cw.ld_mar   = 1'b1;
                target = (state == lc3_pkg::S_LDI_MAR) ? lc3_pkg::S_LD_RD : lc3_pkg::S_ST_MDR;
            end
            lc3_pkg::S_LD_WB: begin
                rom_cw.gate_mdr = 1'b1;
                rom_cw.ld_reg   = 1'b1;
                rom_cw.ld_cc    = 1'b1;
            end
            lc3_pkg::S_ST_MDR: begin          // MDR <- SR via ALU pass
                rom_cw.gate_alu = 1'b1;
                rom_cw.ld_mdr   = 1'b1;
                rom_cw.aluk     = lc3_pkg::ALU_PASS;
                target          = lc3_pkg::S_ST_WR;
            end
            lc3_pkg::S_ST_WR: begin           // 16 | ready -> 18
                rom_cw.mem_en = 1'b1;
                rom_cw.mem_we = 1'b1;
                target        = lc3_pkg::S_ST_WR;
                cond_sel      = lc3_pkg::COND_READY;
            end
            lc3_pkg::S_BR: begin              // 18 | BEN -> 22
                cond_sel = lc3_pkg::COND_BEN;
            end
            lc3_pkg::S_JSR: begin             // R7 <- PC, 20 | IR[11] -> 21
                rom_cw.gate_pc = 1'b1;
                rom_cw.ld_reg  = 1'b1;
                rom_cw.drmux   = 1'b1;
                target         = lc3_pkg::S_JSRR_PC;
                cond_sel       = lc3_pkg::COND_IR11;
            end
            lc3_pkg::S_JMP, lc3_pkg::S_JSRR_PC: begin
                rom_cw.ld_pc    = 1'b1;       // PC <- BaseR + 0
                rom_cw.pcmux    = lc3_pkg::PC_ADDER;
                rom_cw.addr1mux = 1'b1;
                rom_cw.sr1mux   = 1'b1;
            end
            lc3_pkg::S_JSR_PC, lc3_pkg::S_BR_TAKEN: begin
                rom_cw.ld_pc    = 1'b1;
                rom_cw.pcmux    = lc3_pkg::PC_ADDER;
                rom_cw.addr2mux = (state == lc3_pkg::S_JSR_PC) ? lc3_pkg::A2_OFF11 :
                                                                 lc3_pkg::A2_OFF9;
            end
            default: begin
                // RTI, TRAP and reserved fall through as no-ops
            end
        endcase
    end

    always_comb begin
        ctrl        = rom_cw;
        ctrl.ld_mdr = rom_cw.ld_mdr & (~rom_cw.mem_en | mem_ready);  // read data only on ready
    end

    assign mem_en = rom_cw.mem_en;
    assign mem_we = rom_cw.mem_we;

    lc3_microseq i_microseq (
        .target     (target),
        .cond_sel   (cond_sel),
        .ird        (ird),
        .ready      (mem_ready),
        .ben        (ben),
        .ir_11      (ir[11]),
        .next_state (next_state)
    );

endmodule

//--- datapath/lc3_reg_file.sv
/*
 * LC-3 register file R0..R7, one write port, two read ports
 */
`timescale 1ns/1ps
`include "lc3_defs.svh"

module lc3_reg_file (
    input  logic              clk,
    input  logic              reset,
    input  logic              we,
    input  lc3_pkg::reg_idx_t dr,
    input  lc3_pkg::word_t    wdata,
    input  lc3_pkg::reg_idx_t sr1,
    input  lc3_pkg::reg_idx_t sr2,
    output lc3_pkg::word_t    sr1_data,
    output lc3_pkg::word_t    sr2_data
);

    lc3_pkg::word_t regs [`LC3_NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `LC3_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[dr] <= wdata;
        end
    end

    assign sr1_data = regs[sr1];   // read is combinational
    assign sr2_data = regs[sr2];

endmodule

//--- datapath/lc3_datapath.sv
/*
 * LC-3 datapath with IR, PC, MAR, MDR, condition codes and BEN,
 * address adder, ALU, PC and register-number muxes and the internal bus
 */
`timescale 1ns/1ps
`include "lc3_defs.svh"

module lc3_datapath (
    input  logic                clk,
    input  logic                reset,
    input  lc3_pkg::ctrl_word_t ctrl,
    input  lc3_pkg::word_t      mem_rdata,
    output lc3_pkg::word_t      ir,
    output logic                ben,
    output lc3_pkg::word_t      mem_addr,
    output lc3_pkg::word_t      mem_wdata
);

    lc3_pkg::word_t   pc;
    lc3_pkg::word_t   mar;
    lc3_pkg::word_t   mdr;
    lc3_pkg::word_t   bus;
    lc3_pkg::word_t   pc_next;
    lc3_pkg::word_t   addr1;
    lc3_pkg::word_t   addr2;
    lc3_pkg::word_t   adder_out;
    lc3_pkg::word_t   alu_b;
    lc3_pkg::word_t   alu_out;
    lc3_pkg::word_t   sr1_data;
    lc3_pkg::word_t   sr2_data;
    lc3_pkg::reg_idx_t dr;
    lc3_pkg::reg_idx_t sr1;
    logic [2:0]       nzp;
    logic             bus_neg;
    logic             bus_zero;

    assign dr  = ctrl.drmux  ? 3'd7 : ir[11:9];
    assign sr1 = ctrl.sr1mux ? ir[8:6] : ir[11:9];

    // address adder with offsets sign-extended by the cast
    assign addr1 = ctrl.addr1mux ? sr1_data : pc;
    always_comb begin
        case (ctrl.addr2mux)
            lc3_pkg::A2_OFF6:  addr2 = lc3_pkg::word_t'($signed(ir[5:0]));
            lc3_pkg::A2_OFF9:  addr2 = lc3_pkg::word_t'($signed(ir[8:0]));
            lc3_pkg::A2_OFF11: addr2 = lc3_pkg::word_t'($signed(ir[10:0]));
            default:           addr2 = '0;
        endcase
    end
    assign adder_out = addr1 + addr2;

    // imm5 form when IR[5] set
    assign alu_b = ir[5] ? lc3_pkg::word_t'($signed(ir[4:0])) : sr2_data;

    always_comb begin
        case (ctrl.aluk)
            lc3_pkg::ALU_ADD: alu_out = sr1_data + alu_b;
            lc3_pkg::ALU_AND: alu_out = sr1_data & alu_b;
            lc3_pkg::ALU_NOT: alu_out = ~sr1_data;
            default:          alu_out = sr1_data;
        endcase
    end

    // at most one gate is on per state
    always_comb begin
        if (ctrl.gate_pc) begin
            bus = pc;
        end else if (ctrl.gate_mdr) begin
            bus = mdr;
        end else if (ctrl.gate_alu) begin
            bus = alu_out;
        end else if (ctrl.gate_marmux) begin
            bus = adder_out;
        end else begin
            bus = '0;
        end
    end

    always_comb begin
        case (ctrl.pcmux)
            lc3_pkg::PC_ADDER: pc_next = adder_out;
            default:           pc_next = pc + 1'b1;
        endcase
    end

    assign bus_neg  = bus[`LC3_WORD_W-1];
    assign bus_zero = (bus == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            ir  <= '0;
            pc  <= `LC3_RESET_PC;
            mar <= '0;
            mdr <= '0;
            nzp <= 3'b010;      // Z after reset
            ben <= 1'b0;
        end else begin
            if (ctrl.ld_ir) ir <= bus;
            if (ctrl.ld_pc) pc <= pc_next;
            if (ctrl.ld_mar) mar <= bus;
            if (ctrl.ld_mdr) mdr <= ctrl.mem_en ? mem_rdata : bus;
            if (ctrl.ld_cc) nzp <= {bus_neg, bus_zero, ~bus_neg & ~bus_zero};
            if (ctrl.ld_ben) ben <= |(ir[11:9] & nzp);
        end
    end

    assign mem_addr  = mar;
    assign mem_wdata = mdr;

    lc3_reg_file i_reg_file (
        .clk      (clk),
        .reset    (reset),
        .we       (ctrl.ld_reg),
        .dr       (dr),
        .wdata    (bus),
        .sr1      (sr1),
        .sr2      (ir[2:0]),
        .sr1_data (sr1_data),
        .sr2_data (sr2_data)
    );

endmodule

//--- verilog/lc3_core.sv
/*
 * LC-3 core top level: control unit and datapath joined,
 * plain strobe port to an external memory
 */
`timescale 1ns/1ps

module lc3_core (
    input  logic           clk,
    input  logic           reset,
    output logic           mem_en,
    output logic           mem_we,
    output lc3_pkg::word_t mem_addr,
    output lc3_pkg::word_t mem_wdata,
    input  lc3_pkg::word_t mem_rdata,
    input  logic           mem_ready
);

    lc3_pkg::ctrl_word_t ctrl;
    lc3_pkg::word_t      ir;
    logic                ben;

    lc3_ctrl i_ctrl (
        .clk       (clk),
        .reset     (reset),
        .ir        (ir),
        .ben       (ben),
        .mem_ready (mem_ready),
        .ctrl      (ctrl),
        .mem_en    (mem_en),
        .mem_we    (mem_we)
    );

    lc3_datapath i_datapath (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .mem_rdata (mem_rdata),
        .ir        (ir),
        .ben       (ben),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

endmodule

//--- verification/lc3_core_chk.sv
/*
 * Memory port assertions bound to lc3_core
 */
`timescale 1ns/1ps

module lc3_core_chk (
    input logic           clk,
    input logic           reset,
    input logic           mem_en,
    input logic           mem_we,
    input logic           mem_ready,
    input lc3_pkg::word_t mem_addr,
    input lc3_pkg::word_t mem_wdata
);

    int fail_count = 0;    // failed assertions so far

    // idle strobes right after reset
    a_idle_after_reset: assert property (@(posedge clk)
        $past(reset) |-> (!mem_en && !mem_we))
        else begin
            $error("memory strobes active in the cycle after reset");
            fail_count++;
        end

    a_we_needs_en: assert property (@(posedge clk) disable iff (reset)
        mem_we |-> mem_en)
        else begin
            $error("mem_we high without mem_en");
            fail_count++;
        end

    a_stable_wait: assert property (@(posedge clk) disable iff (reset)
        (mem_en && !mem_ready) |=> ($stable(mem_addr) && $stable(mem_we) && $stable(mem_wdata)))
        else begin
            $error("memory request changed while waiting for ready");
            fail_count++;
        end

    a_en_drops: assert property (@(posedge clk) disable iff (reset)
        mem_ready |=> !mem_en)
        else begin
            $error("mem_en still high in the cycle after ready");
            fail_count++;
        end

endmodule

bind lc3_core lc3_core_chk i_core_chk (
    .clk       (clk),
    .reset     (reset),
    .mem_en    (mem_en),
    .mem_we    (mem_we),
    .mem_ready (mem_ready),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata)
);

//--- verification/lc3_checker.sv
/*
 * Store checker: compares every memory write strobe with the next
 * expected store, prints one line per test and a closing count line
 */
`timescale 1ns/1ps
`include "lc3_defs.svh"

module lc3_checker (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   mem_en,
    input  logic                   mem_we,
    input  logic                   mem_ready,
    input  logic [`LC3_WORD_W-1:0] mem_addr,
    input  logic [`LC3_WORD_W-1:0] mem_wdata,
    input  logic [`LC3_WORD_W-1:0] exp_test [64],
    input  logic [`LC3_WORD_W-1:0] exp_addr [64],
    input  logic [`LC3_WORD_W-1:0] exp_data [64],
    input  int                     exp_count,
    output logic                   done,
    output int                     errors
);

    int   idx = 0;
    int   test_stores = 0;
    int   test_bad = 0;
    int   tests_ok = 0;
    int   tests_bad = 0;
    logic first_seen = 1'b0;

    initial begin
        done   = 1'b0;
        errors = 0;
    end

    always @(posedge clk) begin
        if (!reset && mem_en && !first_seen) begin
            first_seen = 1'b1;
            if (mem_addr != `LC3_RESET_PC) begin    // first fetch from reset PC
                $display("[FAIL] %0t: first access at %h, expected %h",
                         $time, mem_addr, `LC3_RESET_PC);
                errors++;
            end
        end
        if (!reset && mem_en && mem_we && mem_ready) begin
            if (idx >= exp_count) begin
                $display("store of %h to %h arrived after the last expected store",
                         mem_wdata, mem_addr);
                errors++;
            end else begin
                test_stores++;
                if (mem_addr != exp_addr[idx] || mem_wdata != exp_data[idx]) begin
                    $display("[FAIL] %0t: test %0d wrote %h to %h, expected %h to %h",
                             $time, exp_test[idx], mem_wdata, mem_addr,
                             exp_data[idx], exp_addr[idx]);
                    test_bad++;
                    errors++;
                end
                // last store of this test
                if (idx + 1 == exp_count || exp_test[idx+1] != exp_test[idx]) begin
                    if (test_bad == 0) begin
                        $display("test %0d: passed, %0d stores", exp_test[idx], test_stores);
                        tests_ok++;
                    end else begin
                        $display("test %0d: failed, %0d of %0d stores wrong",
                                 exp_test[idx], test_bad, test_stores);
                        tests_bad++;
                    end
                    test_stores = 0;
                    test_bad    = 0;
                end
                idx++;
                if (idx == exp_count) begin
                    $display("tests passed %0d, tests failed %0d, errors %0d",
                             tests_ok, tests_bad, errors);
                    done = 1'b1;
                end
            end
        end
    end

endmodule

//--- verification/lc3_tb.sv
/*
 * LC-3 core testbench with clock, reset, latency-randomized memory model,
 * program and expected-store loading from the input file and watchdog
 */
`timescale 1ns/1ps
`include "lc3_defs.svh"

module lc3_tb;

    localparam int MAX_RECS = 512;
    localparam int MAX_EXP  = 64;
    localparam int MAX_LAT  = 3;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   mem_en;
    logic                   mem_we;
    logic [`LC3_WORD_W-1:0] mem_addr;
    logic [`LC3_WORD_W-1:0] mem_wdata;
    logic [`LC3_WORD_W-1:0] mem_rdata = '0;
    logic                   mem_ready = 1'b0;

    logic [`LC3_WORD_W-1:0] recs [MAX_RECS];
    logic [`LC3_WORD_W-1:0] mem [logic [`LC3_WORD_W-1:0]];   // sparse memory
    logic [`LC3_WORD_W-1:0] exp_test [MAX_EXP];
    logic [`LC3_WORD_W-1:0] exp_addr [MAX_EXP];
    logic [`LC3_WORD_W-1:0] exp_data [MAX_EXP];
    int                     exp_count = 0;
    int                     prog_words = 0;
    logic                   loaded = 1'b0;
    logic                   done;
    int                     errors;

    integer seed = 32'h5a5c396f;
    logic   busy = 1'b0;
    int     wait_left = 0;

    always #2 clk = ~clk;    // 4 ns period

    lc3_core i_dut (
        .clk       (clk),
        .reset     (reset),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

    lc3_checker i_checker (
        .clk       (clk),
        .reset     (reset),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_ready (mem_ready),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .exp_test  (exp_test),
        .exp_addr  (exp_addr),
        .exp_data  (exp_data),
        .exp_count (exp_count),
        .done      (done),
        .errors    (errors)
    );

    // split the record stream into program words and expected stores
    task automatic load_records();
        int  r;
        logic more;
        r    = 0;
        more = 1'b1;
        for (int i = 0; i < MAX_RECS; i++) begin
            recs[i] = '0;
        end
        $readmemh("verification/lc3_input.hex", recs);
        while (more && (r + 3 < MAX_RECS)) begin
            if (recs[r] == 16'h0001) begin
                mem[recs[r+1]] = recs[r+2];
                prog_words++;
            end else if (recs[r] == 16'h0002 && exp_count < MAX_EXP) begin
                exp_test[exp_count] = recs[r+1];
                exp_addr[exp_count] = recs[r+2];
                exp_data[exp_count] = recs[r+3];
                exp_count++;
            end else begin
                more = 1'b0;    // end record
            end
            r += 4;
        end
    endtask

    // memory answers after 1..3 falling edges with a one-cycle ready pulse
    always @(negedge clk) begin
        if (reset) begin
            mem_ready <= 1'b0;
            busy = 1'b0;
        end else if (mem_ready) begin
            mem_ready <= 1'b0;
        end else if (mem_en) begin
            if (!busy) begin
                busy = 1'b1;
                wait_left = $unsigned($random(seed)) % MAX_LAT;
            end else begin
                wait_left = wait_left - 1;
            end
            if (wait_left == 0) begin
                busy = 1'b0;
                if (mem_we) begin
                    mem[mem_addr] = mem_wdata;
                end else if (mem.exists(mem_addr)) begin
                    mem_rdata <= mem[mem_addr];
                end else begin
                    mem_rdata <= '0;
                end
                mem_ready <= 1'b1;
            end
        end
    end

    initial begin
        reset = 1'b1;
        load_records();
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        wait (done == 1'b1);
        @(posedge clk);
        if (errors == 0 && i_dut.i_core_chk.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // 40 cycles per program word scaled by the worst latency
    initial begin
        int limit;
        wait (loaded == 1'b1);
        limit = prog_words * 40 * MAX_LAT;
        repeat (limit) @(posedge clk);
        $display("run timed out after %0d cycles, not all expected stores were seen", limit);
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- verification/lc3_input.hex
// kind 0001: program word  <addr> <data> 0000
// kind 0002: expected store <test> <addr> <data>, kind 0000 ends the list
0001 3000 2C5F 0000
0001 3001 5020 0000
0001 3002 1027 0000
0001 3003 1237 0000
0001 3004 1401 0000
0001 3005 967F 0000
0001 3006 5840 0000
0001 3007 5A7A 0000
0001 3008 7380 0000
0001 3009 7581 0000
0001 300A 7782 0000
0001 300B 7983 0000
0001 300C 7B84 0000
0001 300D 1B45 0000
0001 300E 7B85 0000
0001 300F 2051 0000
0001 3010 6390 0000
0001 3011 A451 0000
0001 3012 7186 0000
0001 3013 7387 0000
0001 3014 7588 0000
0001 3015 3050 0000
0001 3016 73BF 0000
0001 3017 B44D 0000
0001 3018 5920 0000
0001 3019 0401 0000
0001 301A 1921 0000
0001 301B 1A20 0000
0001 301C 0C01 0000
0001 301D 1922 0000
0001 301E 0201 0000
0001 301F 1924 0000
0001 3020 2A41 0000
0001 3021 0601 0000
0001 3022 1928 0000
0001 3023 9B3F 0000
0001 3024 0801 0000
0001 3025 192F 0000
0001 3026 0E01 0000
0001 3027 192F 0000
0001 3028 0001 0000
0001 3029 1921 0000
0001 302A 7989 0000
0001 302B E005 0000
0001 302C 718A 0000
0001 302D 4812 0000
0001 302E 4000 0000
0001 302F 798F 0000
0001 3030 798F 0000
0001 3031 7F8B 0000
0001 3032 E203 0000
0001 3033 C040 0000
0001 3034 798F 0000
0001 3035 798F 0000
0001 3036 1461 0000
0001 3037 758C 0000
0001 3038 0FFF 0000
0001 3040 7F8D 0000
0001 3041 C1C0 0000
0001 3060 4000 0000
0001 3061 1234 0000
0001 3062 8001 0000
0001 3063 3064 0000
0001 3064 BEEF 0000
0001 3065 4020 0000
0001 4010 8001 0000
0002 0001 4000 FFFE
0002 0001 4001 0005
0002 0001 4002 0001
0002 0001 4003 0006
0002 0001 4004 FFFA
0002 0001 4005 FFF4
0002 0002 4006 1234
0002 0002 4007 8001
0002 0002 4008 BEEF
0002 0003 3066 1234
0002 0003 3FFF 8001
0002 0003 4020 BEEF
0002 0004 4009 000B
0002 0005 400A 3031
0002 0005 400D 302E
0002 0005 400B 302F
0002 0005 400C 3037
0000 0000 0000 0000

//--- all.f
+incdir+common
common/lc3_pkg.sv
control/lc3_microseq.sv
control/lc3_ctrl.sv
datapath/lc3_reg_file.sv
datapath/lc3_datapath.sv
verilog/lc3_core.sv
verification/lc3_core_chk.sv
verification/lc3_checker.sv
verification/lc3_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the LC-3 core simulation with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module lc3_tb \
    -f all.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vlc3_tb | tee sim.log
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
exit 0
